// ==== source/wts_pkg.sv ====
// --------------------
// Shared types of the wavetable mixer: sample, volume, frequency,
// wave index, channel and bank address words, mix word, the per-channel
// register struct and the CPU request struct
// --------------------

package wts_pkg;

	// Every wave holds this many samples
	localparam int WAVE_LEN = 32;

	typedef logic signed [7:0]	sample_t;
	typedef logic [3:0]			volume_t;
	typedef logic [11:0]		freq_t;
	typedef logic [4:0]			wave_index_t;
	typedef logic [2:0]			channel_id_t;

	// Wave region (channel id >> 1) followed by the wave index
	typedef logic [6:0]			bank_addr_t;

	typedef logic [11:0]		mix_t;

	// Output level for silence in offset binary
	localparam mix_t MIX_MID = 12'h800;

	typedef struct packed {
		volume_t	volume;
		logic		pan_left;
		logic		pan_right;
		freq_t		freq;
	} ch_reg_t;

	typedef struct packed {
		channel_id_t	ch;
		wave_index_t	addr;
		sample_t		data;
		logic			rd;
		logic			wr;
	} cpu_req_t;

endpackage

// ==== source/wts_slot_sequencer.sv ====
// --------------------
// One-hot slot ring, bank address selection per slot and the
// channel register selection aligned to the bank read
// --------------------
`timescale 1ns/1ps

module wts_slot_sequencer #(
	parameter int NUM_CHANNELS = 6
) (
	input  logic									clk,
	input  logic									nreset,
	input  wts_pkg::ch_reg_t [NUM_CHANNELS-1:0]		ch_regs,
	input  wts_pkg::wave_index_t [NUM_CHANNELS-1:0]	wave_index,
	input  wts_pkg::bank_addr_t						cpu_addr,
	output logic [NUM_CHANNELS-1:0]					active,
	output wts_pkg::bank_addr_t [1:0]				bank_addr,
	output logic									bank_sel,
	output wts_pkg::volume_t						volume,
	output logic									pan_left,
	output logic									pan_right
);
	import wts_pkg::*;

	logic [NUM_CHANNELS-1:0]	ff_active;
	channel_id_t				w_cur_ch;
	ch_reg_t					w_cur_reg;
	bank_addr_t					w_ch_addr;
	logic						ff_bank_sel;
	volume_t					ff_volume;
	logic						ff_pan_left;
	logic						ff_pan_right;

	// --------------------
	// Slot ring
	// --------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_active <= {{(NUM_CHANNELS-1){1'b0}}, 1'b1};
		end else begin
			ff_active <= {ff_active[NUM_CHANNELS-2:0], ff_active[NUM_CHANNELS-1]};
		end
	end

	always_comb begin
		w_cur_ch = '0;
		for (int i = 0; i < NUM_CHANNELS; i++) begin
			if (ff_active[i]) begin
				w_cur_ch = channel_id_t'(i);
			end
		end
	end

	// --------------------
	// Bank addressing
	// --------------------
	assign w_cur_reg = ch_regs[w_cur_ch];
	assign w_ch_addr = {w_cur_ch[2:1], wave_index[w_cur_ch]};

	// The bank not read by the channel in this slot is lent to the CPU
	assign bank_addr[0] = w_cur_ch[0] ? cpu_addr : w_ch_addr;
	assign bank_addr[1] = w_cur_ch[0] ? w_ch_addr : cpu_addr;

	// Registered so they arrive with the bank read data
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_bank_sel  <= 1'b0;
			ff_volume    <= '0;
			ff_pan_left  <= 1'b0;
			ff_pan_right <= 1'b0;
		end else begin
			ff_bank_sel  <= w_cur_ch[0];
			ff_volume    <= w_cur_reg.volume;
			ff_pan_left  <= w_cur_reg.pan_left;
			ff_pan_right <= w_cur_reg.pan_right;
		end
	end

	assign active    = ff_active;
	assign bank_sel  = ff_bank_sel;
	assign volume    = ff_volume;
	assign pan_left  = ff_pan_left;
	assign pan_right = ff_pan_right;

endmodule

// ==== source/wts_oscillator.sv ====
// --------------------
// Per-channel oscillator with frequency down-counter and sample index
// --------------------
`timescale 1ns/1ps

module wts_oscillator (
	input  logic					clk,
	input  logic					nreset,
	input  logic					active,
	input  logic					key_on,
	input  wts_pkg::freq_t			freq,
	output wts_pkg::wave_index_t	wave_index
);
	import wts_pkg::*;

	freq_t			ff_count;
	wave_index_t	ff_index;

	// The index steps once every freq+1 visits of this channel's slot
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_count <= '0;
			ff_index <= '0;
		end else if (key_on) begin
			ff_count <= freq;
			ff_index <= '0;
		end else if (active) begin
			if (ff_count == '0) begin
				ff_count <= freq;
				ff_index <= wave_index_t'((ff_index + 1) % WAVE_LEN);
			end else begin
				ff_count <= ff_count - 1'b1;
			end
		end
	end

	assign wave_index = ff_index;

endmodule

// ==== source/wts_cpu_port.sv ====
// --------------------
// CPU access to the wave banks
// Latches a request, waits for a free bank slot, drives write enable
// and returns read data with a one-cycle valid
// --------------------
`timescale 1ns/1ps

module wts_cpu_port #(
	parameter int NUM_CHANNELS = 6
) (
	input  logic						clk,
	input  logic						nreset,
	input  wts_pkg::cpu_req_t			cpu,
	input  logic [NUM_CHANNELS-1:0]		active,
	input  wts_pkg::sample_t [1:0]		bank_q,
	output wts_pkg::bank_addr_t			cpu_addr,
	output logic [1:0]					bank_we,
	output wts_pkg::sample_t			bank_d,
	output wts_pkg::sample_t			sram_q,
	output logic						sram_q_en
);
	import wts_pkg::*;

	cpu_req_t	ff_req;
	logic		ff_pending;
	logic		ff_q_en;
	logic		w_odd_slot;
	logic		w_done;

	always_ff @(posedge clk) begin
		if (cpu.rd || cpu.wr) begin
			ff_req <= cpu;
		end
	end

	always_comb begin
		w_odd_slot = 1'b0;
		for (int i = 1; i < NUM_CHANNELS; i += 2) begin
			w_odd_slot = w_odd_slot | active[i];
		end
	end

	// Bank ch[0] is free whenever the slot parity differs from it
	assign w_done = ff_pending & (w_odd_slot ^ ff_req.ch[0]);

	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_pending <= 1'b0;
			ff_q_en    <= 1'b0;
		end else begin
			if (cpu.rd || cpu.wr) begin
				ff_pending <= 1'b1;
			end else if (w_done) begin
				ff_pending <= 1'b0;
			end
			ff_q_en <= w_done & ff_req.rd;
		end
	end

	assign cpu_addr   = {ff_req.ch[2:1], ff_req.addr};
	assign bank_d     = ff_req.data;
	assign bank_we[0] = w_done & ff_req.wr & ~ff_req.ch[0];
	assign bank_we[1] = w_done & ff_req.wr & ff_req.ch[0];

	// The request stays latched until the host issues the next one
	assign sram_q    = bank_q[ff_req.ch[0]];
	assign sram_q_en = ff_q_en;

endmodule

// ==== source/wts_wave_bank.sv ====
// --------------------
// Synchronous wave memory for half of the channels
// --------------------
`timescale 1ns/1ps

module wts_wave_bank #(
	parameter int NUM_CHANNELS = 6
) (
	input  logic				clk,
	input  logic				we,
	input  wts_pkg::bank_addr_t	addr,
	input  wts_pkg::sample_t	d,
	output wts_pkg::sample_t	q
);
	import wts_pkg::*;

	localparam int DEPTH = NUM_CHANNELS / 2 * WAVE_LEN;

	sample_t	mem [DEPTH];
	bank_addr_t	ff_addr;

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= d;
		end
		ff_addr <= addr;
	end

	assign q = mem[ff_addr];

endmodule

// ==== source/wts_volume.sv ====
// --------------------
// Channel volume stage, signed sample times 4-bit volume
// --------------------
`timescale 1ns/1ps

module wts_volume (
	input  logic					clk,
	input  logic					nreset,
	input  wts_pkg::sample_t [1:0]	bank_q,
	input  logic					bank_sel,
	input  wts_pkg::volume_t		volume,
	output wts_pkg::sample_t		level
);
	import wts_pkg::*;

	sample_t			w_sample;
	logic signed [12:0]	w_product;
	sample_t			ff_level;

	assign w_sample  = bank_q[bank_sel];
	assign w_product = w_sample * $signed({1'b0, volume});

	// Volume 15 gives 15/16 of the sample, so the result fits a sample
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_level <= '0;
		end else begin
			ff_level <= sample_t'(w_product >>> 4);
		end
	end

	assign level = ff_level;

endmodule

// ==== source/wts_stereo_mixer.sv ====
// --------------------
// Stereo mixer with per-side gating, frame accumulation
// and offset-binary output registers
// --------------------
`timescale 1ns/1ps

module wts_stereo_mixer #(
	parameter int NUM_CHANNELS = 6
) (
	input  logic				clk,
	input  logic				nreset,
	input  wts_pkg::sample_t	level,
	input  logic				pan_left,
	input  logic				pan_right,
	input  logic				frame_end,
	output wts_pkg::mix_t		left_out,
	output wts_pkg::mix_t		right_out
);
	import wts_pkg::*;

	// Enough headroom for a full frame of samples
	localparam int ACC_W = $bits(sample_t) + $clog2(NUM_CHANNELS);
	localparam int EXT_W = $bits(mix_t) - ACC_W;

	logic				ff_pan_left;
	logic				ff_pan_right;
	logic [ACC_W-1:0]	w_level_ext;
	logic [ACC_W-1:0]	w_left_add;
	logic [ACC_W-1:0]	w_right_add;
	logic [ACC_W-1:0]	ff_left_acc;
	logic [ACC_W-1:0]	ff_right_acc;
	mix_t				ff_left_out;
	mix_t				ff_right_out;

	function automatic mix_t to_offset(input logic [ACC_W-1:0] acc);
		mix_t full;
		full = {{EXT_W{acc[ACC_W-1]}}, acc};
		return {~full[$bits(mix_t)-1], full[$bits(mix_t)-2:0]};
	endfunction

	// Pan bits trail the level by the volume stage
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_pan_left  <= 1'b0;
			ff_pan_right <= 1'b0;
		end else begin
			ff_pan_left  <= pan_left;
			ff_pan_right <= pan_right;
		end
	end

	assign w_level_ext = {{(ACC_W-$bits(sample_t)){level[$bits(sample_t)-1]}}, level};
	assign w_left_add  = ff_pan_left ? w_level_ext : '0;
	assign w_right_add = ff_pan_right ? w_level_ext : '0;

	// --------------------
	// Frame accumulation
	// --------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			ff_left_acc  <= '0;
			ff_right_acc <= '0;
			ff_left_out  <= MIX_MID;
			ff_right_out <= MIX_MID;
		end else if (frame_end) begin
			ff_left_acc  <= w_left_add;
			ff_right_acc <= w_right_add;
			ff_left_out  <= to_offset(ff_left_acc);
			ff_right_out <= to_offset(ff_right_acc);
		end else begin
			ff_left_acc  <= ff_left_acc + w_left_add;
			ff_right_acc <= ff_right_acc + w_right_add;
		end
	end

	assign left_out  = ff_left_out;
	assign right_out = ff_right_out;

endmodule

// ==== source/wts_mixer_top.sv ====
// --------------------
// Top level of the six-channel wavetable mixer
// Slot sequencer, oscillators, CPU port, wave banks, volume and stereo mix
// --------------------
`timescale 1ns/1ps

module wts_mixer_top #(
	parameter int NUM_CHANNELS = 6
) (
	input  logic								clk,
	input  logic								nreset,
	input  wts_pkg::cpu_req_t					cpu,
	input  logic [NUM_CHANNELS-1:0]				key_on,
	input  wts_pkg::ch_reg_t [NUM_CHANNELS-1:0]	ch_regs,
	output wts_pkg::sample_t					sram_q,
	output logic								sram_q_en,
	output wts_pkg::mix_t						left_out,
	output wts_pkg::mix_t						right_out
);
	import wts_pkg::*;

	logic [NUM_CHANNELS-1:0]		w_active;
	wave_index_t [NUM_CHANNELS-1:0]	w_wave_index;
	bank_addr_t						w_cpu_addr;
	bank_addr_t [1:0]				w_bank_addr;
	logic [1:0]						w_bank_we;
	sample_t						w_bank_d;
	sample_t [1:0]					w_bank_q;
	logic							w_bank_sel;
	volume_t						w_volume;
	logic							w_pan_left;
	logic							w_pan_right;
	sample_t						w_level;

	wts_slot_sequencer #(
		.NUM_CHANNELS	(NUM_CHANNELS)
	) u_sequencer (
		.clk		(clk),
		.nreset		(nreset),
		.ch_regs	(ch_regs),
		.wave_index	(w_wave_index),
		.cpu_addr	(w_cpu_addr),
		.active		(w_active),
		.bank_addr	(w_bank_addr),
		.bank_sel	(w_bank_sel),
		.volume		(w_volume),
		.pan_left	(w_pan_left),
		.pan_right	(w_pan_right)
	);

	for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_osc
		wts_oscillator u_osc (
			.clk		(clk),
			.nreset		(nreset),
			.active		(w_active[i]),
			.key_on		(key_on[i]),
			.freq		(ch_regs[i].freq),
			.wave_index	(w_wave_index[i])
		);
	end

	wts_cpu_port #(
		.NUM_CHANNELS	(NUM_CHANNELS)
	) u_cpu_port (
		.clk		(clk),
		.nreset		(nreset),
		.cpu		(cpu),
		.active		(w_active),
		.bank_q		(w_bank_q),
		.cpu_addr	(w_cpu_addr),
		.bank_we	(w_bank_we),
		.bank_d		(w_bank_d),
		.sram_q		(sram_q),
		.sram_q_en	(sram_q_en)
	);

	// Bank 0 holds the even channels, bank 1 the odd ones
	for (genvar b = 0; b < 2; b++) begin : g_bank
		wts_wave_bank #(
			.NUM_CHANNELS	(NUM_CHANNELS)
		) u_bank (
			.clk	(clk),
			.we		(w_bank_we[b]),
			.addr	(w_bank_addr[b]),
			.d		(w_bank_d),
			.q		(w_bank_q[b])
		);
	end

	wts_volume u_volume (
		.clk		(clk),
		.nreset		(nreset),
		.bank_q		(w_bank_q),
		.bank_sel	(w_bank_sel),
		.volume		(w_volume),
		.level		(w_level)
	);

	// Channel 0 reaches the mixer two cycles after its slot
	wts_stereo_mixer #(
		.NUM_CHANNELS	(NUM_CHANNELS)
	) u_mixer (
		.clk		(clk),
		.nreset		(nreset),
		.level		(w_level),
		.pan_left	(w_pan_left),
		.pan_right	(w_pan_right),
		.frame_end	(w_active[2 % NUM_CHANNELS]),
		.left_out	(left_out),
		.right_out	(right_out)
	);

endmodule

// ==== sim/tb_wts_mixer.sv ====
// --------------------
// Testbench for the wavetable mixer
// Random CPU traffic and channel registers checked against a wave model,
// compare tasks, cycle limit and summary
// --------------------
`timescale 1ns/1ps

module tb_wts_mixer;
	import wts_pkg::*;

	localparam int NUM_CH = 6;
	localparam int SEED = 40;
	// Rough sum of the test lengths in cycles, times a wide margin
	localparam int MAX_CYCLES = 20 * (NUM_CH * WAVE_LEN * 5 + 40 * 9 + 20 * 24 +
		WAVE_LEN * 5 + 48 * 8 + 60 + 30 * 9 + 30);

	logic						clk;
	logic						nreset;
	cpu_req_t					cpu;
	logic [NUM_CH-1:0]			key_on;
	ch_reg_t [NUM_CH-1:0]		ch_regs;
	sample_t					sram_q;
	logic						sram_q_en;
	mix_t						left_out;
	mix_t						right_out;

	sample_t	wave [NUM_CH][WAVE_LEN];
	int			check_count;
	int			error_count;
	int			errors_before;
	int			cycle_count;
	int			seed_draw;

	wts_mixer_top #(
		.NUM_CHANNELS	(NUM_CH)
	) uut (
		.clk		(clk),
		.nreset		(nreset),
		.cpu		(cpu),
		.key_on		(key_on),
		.ch_regs	(ch_regs),
		.sram_q		(sram_q),
		.sram_q_en	(sram_q_en),
		.left_out	(left_out),
		.right_out	(right_out)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Run stopped after %0d cycles before the tests finished", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// --------------------
	// Model and compare tasks
	// --------------------
	function automatic int channel_level(input int ch, input int idx);
		return (int'(wave[ch][idx]) * int'(ch_regs[ch].volume)) >>> 4;
	endfunction

	function automatic mix_t expected_mix(input bit right_side, input int idx);
		int sum;
		int lvl;
		logic pan;
		sum = 0;
		for (int c = 0; c < NUM_CH; c++) begin
			lvl = channel_level(c, idx);
			pan = right_side ? ch_regs[c].pan_right : ch_regs[c].pan_left;
			if (pan) begin
				sum += lvl;
			end
		end
		return mix_t'(sum) ^ 12'h800;
	endfunction

	task automatic check_sample(input sample_t got, input sample_t expected, input string what);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("[FAIL] %0t ns: %s read %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic check_mix(input mix_t got, input mix_t expected, input string what);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic finish_test(input int num, input string name);
		$display("Test %0d (%s) finished with %0d errors", num, name,
			error_count - errors_before);
		errors_before = error_count;
	endtask

	// --------------------
	// CPU and register stimulus
	// --------------------
	function automatic cpu_req_t build_request(input channel_id_t ch, input wave_index_t addr,
		input sample_t data, input logic rd, input logic wr);
		cpu_req_t r;
		r.ch = ch;
		r.addr = addr;
		r.data = data;
		r.rd = rd;
		r.wr = wr;
		return r;
	endfunction

	task automatic write_wave(input channel_id_t ch, input wave_index_t addr, input sample_t data);
		@(posedge clk);
		cpu <= build_request(ch, addr, data, 1'b0, 1'b1);
		@(posedge clk);
		cpu <= build_request(ch, addr, data, 1'b0, 1'b0);
		repeat (3) @(posedge clk);
		wave[ch][addr] = data;
	endtask

	// Counts the valid pulses in the cycles after the strobe
	task automatic read_back(input channel_id_t ch, input wave_index_t addr);
		int pulses;
		pulses = 0;
		@(posedge clk);
		cpu <= build_request(ch, addr, '0, 1'b1, 1'b0);
		@(posedge clk);
		cpu <= build_request(ch, addr, '0, 1'b0, 1'b0);
		for (int k = 1; k <= 7; k++) begin
			@(negedge clk);
			if (sram_q_en) begin
				pulses++;
				if (k > 4) begin
					error_count++;
					$display("Read of channel %0d index %0d was valid only %0d cycles after the strobe",
						ch, addr, k);
				end
				check_sample(sram_q, wave[ch][addr], "read-back");
			end
			@(posedge clk);
		end
		if (pulses != 1) begin
			error_count++;
			$display("Read of channel %0d index %0d gave %0d valid pulses instead of one",
				ch, addr, pulses);
		end
	endtask

	// Slow oscillators keep every channel at index 0
	task automatic load_playback_regs(input bit both_pans);
		ch_reg_t r;
		@(posedge clk);
		for (int c = 0; c < NUM_CH; c++) begin
			r.volume = volume_t'($urandom);
			r.pan_left = both_pans | 1'($urandom);
			r.pan_right = both_pans | 1'($urandom);
			r.freq = 12'hfff;
			ch_regs[c] <= r;
		end
		key_on <= '1;
		@(posedge clk);
		key_on <= '0;
	endtask

	task automatic settle();
		repeat (20) @(posedge clk);
		@(negedge clk);
	endtask

	// --------------------
	// Test sequence
	// --------------------
	initial begin
		int idx;
		int pick;
		int start_ch;
		mix_t prev;
		mix_t exp_left;
		mix_t exp_right;
		ch_reg_t r;

		clk = 1'b0;
		nreset = 1'b0;
		cpu = '0;
		key_on = '0;
		ch_regs = '0;
		check_count = 0;
		error_count = 0;
		errors_before = 0;
		cycle_count = 0;
		seed_draw = $urandom(SEED);

		repeat (5) @(posedge clk);
		nreset <= 1'b1;

		for (int n = 0; n < 12; n++) begin
			@(negedge clk);
			check_mix(left_out, 12'h800, "left_out after reset");
			check_mix(right_out, 12'h800, "right_out after reset");
			if (sram_q_en !== 1'b0) begin
				error_count++;
				$display("sram_q_en was raised after reset with no request");
			end
		end
		finish_test(1, "reset state");

		for (int c = 0; c < NUM_CH; c++) begin
			for (int a = 0; a < WAVE_LEN; a++) begin
				write_wave(channel_id_t'(c), wave_index_t'(a), sample_t'($urandom));
			end
		end
		for (int n = 0; n < 40; n++) begin
			read_back(channel_id_t'($urandom % NUM_CH), wave_index_t'($urandom));
		end
		finish_test(2, "wave write and read-back");

		for (int n = 0; n < 20; n++) begin
			load_playback_regs(1'b0);
			settle();
			check_mix(left_out, expected_mix(1'b0, 0), "left_out at index 0");
			check_mix(right_out, expected_mix(1'b1, 0), "right_out at index 0");
		end
		finish_test(3, "random register sets");

		// Evenly spaced samples keep every scaled step distinct
		for (int a = 0; a < WAVE_LEN; a++) begin
			write_wave(3'd0, wave_index_t'(a), sample_t'(a * 8 - 128));
		end
		@(posedge clk);
		for (int c = 0; c < NUM_CH; c++) begin
			r = '0;
			if (c == 0) begin
				r.volume = 4'd15;
				r.pan_left = 1'b1;
				r.pan_right = 1'b1;
			end
			ch_regs[c] <= r;
		end
		key_on <= 6'b000001;
		@(posedge clk);
		key_on <= '0;
		repeat (18) @(posedge clk);
		@(negedge clk);
		idx = -1;
		for (int j = 0; j < WAVE_LEN; j++) begin
			if (left_out == expected_mix(1'b0, j)) begin
				idx = j;
			end
		end
		if (idx < 0) begin
			error_count++;
			$display("left_out %h matches no sample of channel 0", left_out);
		end else begin
			for (int step = 0; step < 40; step++) begin
				prev = left_out;
				for (int n = 0; n < 12 && left_out == prev; n++) begin
					@(negedge clk);
				end
				if (left_out == prev) begin
					error_count++;
					$display("left_out did not change within two frames at step %0d", step);
				end else begin
					idx = (idx + 1) % WAVE_LEN;
					check_mix(left_out, expected_mix(1'b0, idx), "left_out of channel 0");
				end
			end
		end
		finish_test(4, "single channel sweep");

		load_playback_regs(1'b1);
		settle();
		exp_left = expected_mix(1'b0, 0);
		check_mix(left_out, exp_left, "left_out with all pans");
		check_mix(right_out, expected_mix(1'b1, 0), "right_out with all pans");
		// A channel with a nonzero level makes its removal visible on the right side
		start_ch = $urandom % NUM_CH;
		pick = start_ch;
		for (int k = NUM_CH - 1; k >= 0; k--) begin
			if (channel_level((start_ch + k) % NUM_CH, 0) != 0) begin
				pick = (start_ch + k) % NUM_CH;
			end
		end
		@(posedge clk);
		ch_regs[pick].pan_right <= 1'b0;
		settle();
		check_mix(left_out, exp_left, "left_out after right pan cleared");
		check_mix(right_out, expected_mix(1'b1, 0), "right_out after right pan cleared");
		finish_test(5, "right pan removal");

		load_playback_regs(1'b0);
		settle();
		exp_left = expected_mix(1'b0, 0);
		exp_right = expected_mix(1'b1, 0);
		for (int n = 0; n < 30; n++) begin
			if ($urandom % 2) begin
				write_wave(channel_id_t'($urandom % NUM_CH), wave_index_t'(1 + $urandom % 31),
					sample_t'($urandom));
			end else begin
				read_back(channel_id_t'($urandom % NUM_CH), wave_index_t'($urandom));
			end
			@(negedge clk);
			check_mix(left_out, exp_left, "left_out during CPU traffic");
			check_mix(right_out, exp_right, "right_out during CPU traffic");
		end
		finish_test(6, "CPU traffic during playback");

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== wts_mixer_top.f ====
source/wts_pkg.sv
source/wts_slot_sequencer.sv
source/wts_oscillator.sv
source/wts_cpu_port.sv
source/wts_wave_bank.sv
source/wts_volume.sv
source/wts_stereo_mixer.sv
source/wts_mixer_top.sv
sim/tb_wts_mixer.sv

// ==== Makefile ====
TOP = tb_wts_mixer

all: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f wts_mixer_top.f

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f wts_mixer_top.f

clean:
	rm -rf obj_dir

.PHONY: all build lint clean
